/* project.f */
+incdir+verilog
verilog/xreg_pkg.sv
verilog/reg_bus_if.sv
verilog/bus_interface.sv
verilog/reg_control.sv
verilog/vram.sv
verilog/xreg_top.sv
tests/xreg_tb.sv

/* Makefile */
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module xreg_tb -f project.f \
		--Mdir obj_dir -o xreg_sim
	./obj_dir/xreg_sim | tee $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* tests/xreg_tb.sv */
// ************************************************
// host register port testbench
// random bus cycles from an LFSR, checked against a
// register and video RAM model
// ************************************************

`default_nettype none
`timescale 1ns/1ps

`include "xreg_cfg.svh"

module xreg_tb
    import xreg_pkg::*;
;
    localparam int CLK_PERIOD = 40;
    localparam int ROUNDS = 4, N_PAIR = 6, N_SEQ = 48, N_RAW = 8, N_MIX = 300;
    localparam int FILL_WORDS = 1 << `XREG_VRAM_ADDR_W;
    localparam int BUS_CYCLES = ROUNDS * 16 + 44 + N_PAIR * 4 + 12 + FILL_WORDS * 2
                              + N_SEQ * 4 + N_RAW * 8 + N_MIX * 2;
    localparam int WATCHDOG_CLKS = BUS_CYCLES * 10 + 250;  // 10 clk per bus cycle plus margin
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic clk, reset_i, cs_n, rd_nwr, bytesel;
    reg_num_t reg_num;
    logic [7:0] data_in, data_out;

    word_t m_mem [0:FILL_WORDS-1];          // model video RAM
    word_t m_wr_addr, m_rd_addr, m_wr_incr, m_rd_incr, m_latch;
    reg_num_t m_even_reg;                   // register of the last even write
    logic [7:0] m_even_data;
    logic [31:0] lfsr_state;
    int byte_errors = 0, word_errors = 0;

    xreg_top i_dut (
        .clk(clk), .reset_i(reset_i), .bus_cs_n_i(cs_n), .bus_rd_nwr_i(rd_nwr),
        .bus_reg_num_i(reg_num), .bus_bytesel_i(bytesel), .bus_data_i(data_in),
        .bus_data_o(data_out)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);   // galois, shift right
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);             // one step per bit
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic word_t reg_value(input reg_num_t r);
        case (r)
            REG_WR_ADDR: return m_wr_addr;
            REG_RD_ADDR: return m_rd_addr;
            REG_WR_INCR: return m_wr_incr;
            REG_RD_INCR: return m_rd_incr;
            REG_DATA:    return m_latch;
            default:     return '0;                         // 5 to 15 read zero
        endcase
    endfunction

    task automatic apply_write(input reg_num_t r, input logic sel, input logic [7:0] d);
        word_t w;
        logic hit;
        w = (r == m_even_reg) ? {m_even_data, d} : {8'h00, d};  // pairing rule
        if (!sel) begin
            m_even_reg  = r;
            m_even_data = d;
        end else begin
            case (r)
                REG_WR_ADDR: m_wr_addr = w;
                REG_WR_INCR: m_wr_incr = w;
                REG_RD_INCR: m_rd_incr = w;
                REG_RD_ADDR: begin
                    m_rd_addr = w;
                    m_latch   = m_mem[vram_addr_t'(w)];         // prefetch new address
                end
                REG_DATA: begin
                    hit = (vram_addr_t'(m_wr_addr) == vram_addr_t'(m_rd_addr));
                    m_mem[vram_addr_t'(m_wr_addr)] = w;
                    m_wr_addr = m_wr_addr + m_wr_incr;
                    if (hit) m_latch = w;                       // refresh stale prefetch
                end
                default: ;
            endcase
        end
    endtask

    task automatic advance_read(input reg_num_t r);
        if (r == REG_DATA) begin
            m_rd_addr = m_rd_addr + m_rd_incr;                  // odd DATA byte consumed
            m_latch   = m_mem[vram_addr_t'(m_rd_addr)];
        end
    endtask

    task automatic run_cycle(input logic rd_level, input reg_num_t r, input logic sel,
                             input logic [7:0] d, output logic [7:0] q);
        @(posedge clk);
        cs_n    <= `XREG_CS_ENABLED;                        // active for 6 clk
        rd_nwr  <= rd_level;
        reg_num <= r;
        bytesel <= sel;
        data_in <= d;
        repeat (5) @(posedge clk);
        @(negedge clk);
        q = data_out;                                       // last active clock
        @(posedge clk);
        cs_n <= ~`XREG_CS_ENABLED;
        repeat (3) @(posedge clk);                          // 4 clk idle
    endtask

    task automatic bus_write_byte(input reg_num_t r, input logic sel, input logic [7:0] d);
        logic [7:0] ignored;
        run_cycle(~`XREG_RNW_READ, r, sel, d, ignored);
        apply_write(r, sel, d);
    endtask

    task automatic bus_read_byte(input reg_num_t r, input logic sel, output logic [7:0] q);
        run_cycle(`XREG_RNW_READ, r, sel, 8'h00, q);
    endtask

    task automatic write_word(input reg_num_t r, input word_t w);
        bus_write_byte(r, 1'b0, w[15:8]);                   // even byte first
        bus_write_byte(r, 1'b1, w[7:0]);
    endtask

    task automatic read_word(input reg_num_t r, output word_t w);
        logic [7:0] hi, lo;
        bus_read_byte(r, 1'b0, hi);
        bus_read_byte(r, 1'b1, lo);
        w = {hi, lo};
        advance_read(r);
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp) begin
            byte_errors++;
            $display("[ERROR] %0t ns: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            word_errors++;
            $display("[ERROR] %0t ns: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    initial begin
        #(WATCHDOG_CLKS * CLK_PERIOD);
        $display("Timeout: the run hung and did not end within %0d clock cycles", WATCHDOG_CLKS);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        word_t w, got, start;
        reg_num_t r, rb;
        logic sel;
        logic [7:0] d, q;
        logic [1:0] op;
        int i, k;
        {reset_i, cs_n, rd_nwr, reg_num, bytesel, data_in} = {1'b1, ~`XREG_CS_ENABLED, 14'h0};
        {m_wr_addr, m_rd_addr, m_wr_incr, m_rd_incr, m_latch} = '0;
        m_even_reg  = 4'hF;                                 // matches reset, nothing paired
        m_even_data = 8'h00;
        lfsr_state  = 32'd71694;
        repeat (3) @(posedge clk);
        reset_i <= 1'b0;
        for (k = 0; k < ROUNDS; k++) begin                  // register read-back
            for (i = 0; i < 4; i++) begin
                w = word_t'(take_bits(16));
                write_word(reg_num_t'(i), w);
                bus_read_byte(reg_num_t'(i), 1'b0, q);
                check_byte(q, w[15:8], $sformatf("reg %0d even byte", i));
                bus_read_byte(reg_num_t'(i), 1'b1, q);
                check_byte(q, w[7:0], $sformatf("reg %0d odd byte", i));
            end
        end
        for (i = 5; i < 16; i++) begin                      // unused registers
            write_word(reg_num_t'(i), word_t'(take_bits(16)));
            bus_read_byte(reg_num_t'(i), 1'b0, q);
            check_byte(q, 8'h00, $sformatf("unused reg %0d even byte", i));
            bus_read_byte(reg_num_t'(i), 1'b1, q);
            check_byte(q, 8'h00, $sformatf("unused reg %0d odd byte", i));
        end
        for (k = 0; k < N_PAIR; k++) begin                  // odd byte to another register
            r  = reg_num_t'(take_bits(2));
            rb = r ^ reg_num_t'(take_bits(1) + 32'd1);
            bus_write_byte(r, 1'b0, 8'(take_bits(8)));
            d = 8'(take_bits(8));
            bus_write_byte(rb, 1'b1, d);
            read_word(rb, got);
            check_word(got, {8'h00, d}, $sformatf("unpaired write to reg %0d", rb));
        end
        write_word(REG_WR_INCR, 16'h0001);                  // fill every VRAM word
        write_word(REG_WR_ADDR, 16'h0000);
        for (i = 0; i < FILL_WORDS; i++) write_word(REG_DATA, word_t'(take_bits(16)));
        write_word(REG_WR_INCR, {8'(take_bits(8)), 8'(take_bits(3)) + 8'd1});
        write_word(REG_WR_ADDR, {8'(take_bits(8)), 8'hF8 | 8'(take_bits(3))});  // wraps soon
        for (i = 0; i < N_SEQ; i++) write_word(REG_DATA, word_t'(take_bits(16)));
        write_word(REG_RD_INCR, {8'(take_bits(8)), 8'(take_bits(3)) + 8'd1});
        write_word(REG_RD_ADDR, {8'(take_bits(8)), 8'hF0 | 8'(take_bits(4))});
        for (i = 0; i < N_SEQ; i++) begin
            w = reg_value(REG_DATA);
            read_word(REG_DATA, got);
            check_word(got, w, $sformatf("sequential DATA read %0d", i));
        end
        for (k = 0; k < N_RAW; k++) begin                   // write hits the read address
            start = word_t'(take_bits(16));
            write_word(REG_RD_ADDR, start);
            write_word(REG_WR_ADDR, {8'(take_bits(8)), start[7:0]});
            w = word_t'(take_bits(16));
            write_word(REG_DATA, w);
            read_word(REG_DATA, got);
            check_word(got, w, $sformatf("DATA read after write at %h", start));
        end
        for (k = 0; k < N_MIX; k++) begin                   // random mix
            op = 2'(take_bits(2));
            case (op)
                2'd0: write_word(REG_DATA, word_t'(take_bits(16)));
                2'd1: begin
                    w = reg_value(REG_DATA);
                    read_word(REG_DATA, got);
                    check_word(got, w, $sformatf("mixed DATA read %0d", k));
                end
                2'd2: begin
                    r   = reg_num_t'(take_bits(4));
                    sel = take_bits(1) != 0;
                    bus_write_byte(r, sel, 8'(take_bits(8)));
                end
                2'd3: begin
                    r   = reg_num_t'(take_bits(3));
                    sel = take_bits(1) != 0;
                    w   = reg_value(r);
                    bus_read_byte(r, sel, q);
                    check_byte(q, sel ? w[7:0] : w[15:8], $sformatf("mixed read reg %0d", r));
                    if (sel) advance_read(r);
                end
            endcase
        end
        repeat (4) @(posedge clk);
        $display("byte mismatches: %0d, word mismatches: %0d", byte_errors, word_errors);
        if (byte_errors + word_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/xreg_top.sv */
// ************************************************
// host register port top level
// bus port, register control and video RAM
// ************************************************

`default_nettype none
`timescale 1ns/1ps

`include "xreg_cfg.svh"

module xreg_top
    import xreg_pkg::*;
(
    input  logic        clk,
    input  logic        reset_i,
    input  logic        bus_cs_n_i,         // chip select
    input  logic        bus_rd_nwr_i,       // read / not write
    input  reg_num_t    bus_reg_num_i,      // register number
    input  logic        bus_bytesel_i,      // byte select
    input  logic [7:0]  bus_data_i,         // host write data
    output logic [7:0]  bus_data_o          // host read data
);

    reg_bus_if  reg_bus ();                 // port to control link

    logic       vram_we;
    vram_addr_t vram_waddr;
    word_t      vram_wdata;
    logic       vram_re;
    vram_addr_t vram_raddr;
    word_t      vram_rdata;

    bus_interface i_bus_interface (
        .clk           (clk),
        .reset_i       (reset_i),
        .bus_cs_n_i    (bus_cs_n_i),
        .bus_rd_nwr_i  (bus_rd_nwr_i),
        .bus_reg_num_i (bus_reg_num_i),
        .bus_bytesel_i (bus_bytesel_i),
        .bus_data_i    (bus_data_i),
        .bus_data_o    (bus_data_o),
        .bus           (reg_bus.port)
    );

    reg_control i_reg_control (
        .clk          (clk),
        .reset_i      (reset_i),
        .bus          (reg_bus.ctrl),
        .vram_we_o    (vram_we),
        .vram_waddr_o (vram_waddr),
        .vram_wdata_o (vram_wdata),
        .vram_re_o    (vram_re),
        .vram_raddr_o (vram_raddr),
        .vram_rdata_i (vram_rdata)
    );

    vram #(
        .ADDR_W (`XREG_VRAM_ADDR_W)
    ) i_vram (
        .clk     (clk),
        .we_i    (vram_we),
        .waddr_i (vram_waddr),
        .wdata_i (vram_wdata),
        .re_i    (vram_re),
        .raddr_i (vram_raddr),
        .rdata_o (vram_rdata)
    );

endmodule

`default_nettype wire

/* verilog/vram.sv */
// ************************************************
// video RAM
// dual-port word memory, registered read of old data
// ************************************************

`default_nettype none
`timescale 1ns/1ps

module vram
    import xreg_pkg::*;
#(
    parameter int ADDR_W = 8                    // word address width
) (
    input  logic              clk,
    input  logic              we_i,             // write enable
    input  logic [ADDR_W-1:0] waddr_i,          // write address
    input  word_t             wdata_i,          // write data
    input  logic              re_i,             // read enable
    input  logic [ADDR_W-1:0] raddr_i,          // read address
    output word_t             rdata_o           // read data, next cycle
);

    word_t mem [0:(1 << ADDR_W)-1];             // word storage

    // same-cycle read of a written address returns the old word
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
        if (re_i) begin
            rdata_o <= mem[raddr_i];            // holds until next re
        end
    end

    a_waddr_known: assert property (@(posedge clk)
        we_i |-> !$isunknown(waddr_i));

endmodule

`default_nettype wire

/* verilog/reg_control.sv */
// ************************************************
// register control
// address and increment registers, VRAM writes with
// auto-increment and the read prefetch latch
// ************************************************

`default_nettype none
`timescale 1ns/1ps

module reg_control
    import xreg_pkg::*;
(
    input  logic        clk,
    input  logic        reset_i,
    reg_bus_if.ctrl     bus,                // strobes from host port
    output logic        vram_we_o,          // VRAM write enable
    output vram_addr_t  vram_waddr_o,       // VRAM write address
    output word_t       vram_wdata_o,       // VRAM write data
    output logic        vram_re_o,          // VRAM read enable
    output vram_addr_t  vram_raddr_o,       // VRAM read address
    input  word_t       vram_rdata_i        // VRAM data, one cycle after re
);

    word_t   wr_addr;                       // next VRAM write address
    word_t   rd_addr;                       // current VRAM read address
    word_t   wr_incr;                       // added after each DATA write
    word_t   rd_incr;                       // added after each DATA read
    word_t   rd_latch;                      // prefetched word at rd_addr

    reg_id_e reg_id;                        // decoded register number
    logic    data_wr;                       // DATA write strobe
    logic    data_rd;                       // DATA read strobe
    logic    raw_hit;                       // DATA write lands on rd_addr
    logic    pf_trig;                       // start a prefetch
    logic    pf_req;                        // prefetch requested, re next cycle
    logic    pf_fill;                       // VRAM data valid for the latch
    logic    pf_busy;                       // prefetch still in flight

    assign reg_id  = reg_id_e'(bus.reg_num);
    assign data_wr = bus.write_strobe && (reg_id == REG_DATA);
    assign data_rd = bus.read_strobe && (reg_id == REG_DATA);
    assign raw_hit = data_wr && (vram_addr_t'(wr_addr) == vram_addr_t'(rd_addr));

    // new read address, consumed word, or stale word
    assign pf_trig = (bus.write_strobe && (reg_id == REG_RD_ADDR)) || data_rd || raw_hit;
    assign pf_busy = pf_req || vram_re_o || pf_fill;

    // registers, write issue and prefetch sequencing
    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_addr   <= '0;
            rd_addr   <= '0;
            wr_incr   <= '0;
            rd_incr   <= '0;
            rd_latch  <= '0;
            vram_we_o <= 1'b0;
            vram_re_o <= 1'b0;
            pf_req    <= 1'b0;
            pf_fill   <= 1'b0;
        end else begin
            vram_we_o <= 1'b0;                          // single cycle write
            if (bus.write_strobe) begin
                case (reg_id)
                    REG_WR_ADDR: wr_addr <= bus.wr_word;
                    REG_RD_ADDR: rd_addr <= bus.wr_word;
                    REG_WR_INCR: wr_incr <= bus.wr_word;
                    REG_RD_INCR: rd_incr <= bus.wr_word;
                    REG_DATA: begin
                        vram_we_o <= 1'b1;              // write goes out next cycle
                        wr_addr   <= wr_addr + wr_incr; // step alongside the write
                    end
                    default: ;                          // 5 to 15 ignored
                endcase
            end
            if (data_rd) begin
                rd_addr <= rd_addr + rd_incr;           // step after odd byte read
            end

            // re one cycle after the request so a same-address write lands first
            pf_req    <= pf_trig;
            vram_re_o <= pf_req;
            pf_fill   <= vram_re_o;
            if (pf_fill) begin
                rd_latch <= vram_rdata_i;               // word for the next DATA read
            end
        end
    end

    // VRAM address and data
    always_ff @(posedge clk) begin
        if (data_wr) begin
            vram_waddr_o <= vram_addr_t'(wr_addr);      // address before the step
            vram_wdata_o <= bus.wr_word;
        end
        if (pf_req) begin
            vram_raddr_o <= vram_addr_t'(rd_addr);      // rd_addr already updated
        end
    end

    // read-back mux
    always_comb begin
        case (reg_id)
            REG_WR_ADDR: bus.rd_word = wr_addr;
            REG_RD_ADDR: bus.rd_word = rd_addr;
            REG_WR_INCR: bus.rd_word = wr_incr;
            REG_RD_INCR: bus.rd_word = rd_incr;
            REG_DATA:    bus.rd_word = rd_latch;
            default:     bus.rd_word = '0;             // unused registers
        endcase
    end

    // host bus spacing keeps prefetches apart
    a_pf_no_overlap: assert property (@(posedge clk) disable iff (reset_i)
        pf_trig |-> !pf_busy);

    a_we_single: assert property (@(posedge clk) disable iff (reset_i)
        vram_we_o |=> !vram_we_o);

endmodule

`default_nettype wire

/* verilog/bus_interface.sv */
// ************************************************
// host bus port
// synchronizes the 8-bit bus, pairs bytes into words
// and selects the outgoing read byte
// ************************************************

`default_nettype none
`timescale 1ns/1ps

`include "xreg_cfg.svh"

module bus_interface
    import xreg_pkg::*;
(
    input  logic        clk,
    input  logic        reset_i,
    input  logic        bus_cs_n_i,         // chip select
    input  logic        bus_rd_nwr_i,       // read / not write
    input  reg_num_t    bus_reg_num_i,      // register number
    input  logic        bus_bytesel_i,      // 0 even byte, 1 odd byte
    input  logic [7:0]  bus_data_i,         // write data from host
    output logic [7:0]  bus_data_o,         // read data to host
    reg_bus_if.port     bus                 // to register control
);

    // select history, newest sample enters at bit 3
    logic [3:0] sel_r;

    // two-stage synchronizers, index 1 is the first stage
    logic [1:0] read_r;
    logic [1:0] bytesel_r;
    reg_num_t   reg_num_r [2];
    logic [7:0] data_r [2];

    // synchronized views
    logic       sel_rise;
    logic       write;
    logic       bytesel;
    reg_num_t   reg_num;
    logic [7:0] data;

    // even byte holding register
    reg_num_t   even_reg;               // register of held even byte
    logic [7:0] even_data;              // held even byte

    assign sel_rise = (sel_r[2:0] == 3'b110);   // two active samples after idle, glitch ignored
    assign write    = ~read_r[0];
    assign bytesel  = bytesel_r[0];
    assign reg_num  = reg_num_r[0];
    assign data     = data_r[0];

    // select history needs a clean start
    always_ff @(posedge clk) begin
        if (reset_i) begin
            sel_r <= 4'b0000;
        end else begin
            sel_r <= {(bus_cs_n_i == `XREG_CS_ENABLED), sel_r[3:1]};  // active high inside
        end
    end

    // payload synchronizers
    always_ff @(posedge clk) begin
        read_r       <= {(bus_rd_nwr_i == `XREG_RNW_READ), read_r[1]};
        bytesel_r    <= {bus_bytesel_i, bytesel_r[1]};
        reg_num_r[1] <= bus_reg_num_i;
        reg_num_r[0] <= reg_num_r[1];
        data_r[1]    <= bus_data_i;
        data_r[0]    <= data_r[1];
    end

    // strobe generation and even byte capture
    always_ff @(posedge clk) begin
        if (reset_i) begin
            bus.write_strobe <= 1'b0;
            bus.read_strobe  <= 1'b0;
            bus.reg_num      <= '0;
            even_reg         <= 4'hF;               // no pairing until an even write
        end else begin
            bus.write_strobe <= 1'b0;               // default idle
            bus.read_strobe  <= 1'b0;
            bus.reg_num      <= reg_num;            // follows the bus every cycle
            if (sel_rise) begin
                if (write) begin
                    if (bytesel) begin
                        bus.write_strobe <= 1'b1;   // odd byte completes the word
                    end else begin
                        even_reg <= reg_num;        // remember for the odd byte
                    end
                end else if (bytesel) begin
                    bus.read_strobe <= 1'b1;        // odd byte read done
                end
            end
        end
    end

    // even byte data, captured with its register number
    always_ff @(posedge clk) begin
        if (sel_rise && write && !bytesel) begin
            even_data <= data;
        end
    end

    // paired word, high byte only from a matching even write
    always_comb begin
        if (reg_num == even_reg) begin
            bus.wr_word = {even_data, data};
        end else begin
            bus.wr_word = {8'h00, data};
        end
    end

    // high byte on even select
    assign bus_data_o = bytesel ? bus.rd_word[7:0] : bus.rd_word[15:8];

    a_strobe_excl: assert property (@(posedge clk) disable iff (reset_i)
        !(bus.write_strobe && bus.read_strobe));

    a_wr_single: assert property (@(posedge clk) disable iff (reset_i)
        bus.write_strobe |=> !bus.write_strobe);

    a_rd_single: assert property (@(posedge clk) disable iff (reset_i)
        bus.read_strobe |=> !bus.read_strobe);

endmodule

`default_nettype wire

/* verilog/reg_bus_if.sv */
// ************************************************
// register bus between host port and control
// strobes, register number and data words
// ************************************************

`default_nettype none
`timescale 1ns/1ps

interface reg_bus_if
    import xreg_pkg::*;
();

    logic       write_strobe;   // one cycle, word write complete
    logic       read_strobe;    // one cycle, odd byte of a read taken
    reg_num_t   reg_num;        // register being accessed
    word_t      wr_word;        // paired word for write_strobe
    word_t      rd_word;        // read value for reg_num, combinational

    // host side, produces strobes
    modport port (
        output write_strobe,
        output read_strobe,
        output reg_num,
        output wr_word,
        input  rd_word
    );

    // register side
    modport ctrl (
        input  write_strobe,
        input  read_strobe,
        input  reg_num,
        input  wr_word,
        output rd_word
    );

endinterface

`default_nettype wire

/* verilog/xreg_pkg.sv */
// ************************************************
// host register port types
// words, register numbers, VRAM addresses and register ids
// ************************************************

`default_nettype none

`include "xreg_cfg.svh"

package xreg_pkg;

    typedef logic [15:0] word_t;                            // register or VRAM word
    typedef logic [3:0]  reg_num_t;                         // host register number
    typedef logic [`XREG_VRAM_ADDR_W-1:0] vram_addr_t;      // VRAM word address

    // decoded register ids, 5 to 15 are unused
    typedef enum reg_num_t {
        REG_WR_ADDR = 4'd0,                                 // VRAM write address
        REG_RD_ADDR = 4'd1,                                 // VRAM read address
        REG_WR_INCR = 4'd2,                                 // write address step
        REG_RD_INCR = 4'd3,                                 // read address step
        REG_DATA    = 4'd4                                  // VRAM data port
    } reg_id_e;

endpackage

`default_nettype wire

/* verilog/xreg_cfg.svh */
// ************************************************
// host register port configuration
// bus signal polarities and video RAM size
// ************************************************

`ifndef XREG_CFG_SVH
`define XREG_CFG_SVH

// video RAM word address width, 256 words
`define XREG_VRAM_ADDR_W    8

// host bus levels
`define XREG_CS_ENABLED     1'b0    // chip select active low
`define XREG_RNW_READ       1'b1    // rd_nwr high means read

`endif
